// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui
    } alu_op_e;

    // LT/GE serve signed and unsigned branches alike
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JAL,
        BR_JALR
    } branch_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK         // pc + 4 for jal/jalr
    } wb_e;

endpackage

// ==== hw/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
    input  logic [rv_pkg::XLEN-1:0]   instr,
    output logic [rv_pkg::REG_AW-1:0] rs1,
    output logic [rv_pkg::REG_AW-1:0] rs2,
    output logic [rv_pkg::REG_AW-1:0] rd,
    output logic                      reg_we,
    output logic                      mem_we,
    output rv_pkg::alu_op_e           alu_op,
    output logic                      a_sel_pc,
    output logic                      b_sel_imm,
    output rv_pkg::wb_e               wb_sel,
    output rv_pkg::branch_e           branch_kind,
    output logic [rv_pkg::XLEN-1:0]   imm
);
    import rv_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    alu_op_e         arith_op;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rd        = instr[11:7];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];

    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Shared by OP and OP_IMM, sub handled separately
    always_comb
    begin
        case (funct3)
            3'b000:  arith_op = ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb
    begin
        reg_we      = 1'b0;     // unknown opcodes fall through as nop
        mem_we      = 1'b0;
        alu_op      = ALU_ADD;
        a_sel_pc    = 1'b0;
        b_sel_imm   = 1'b0;
        wb_sel      = WB_ALU;
        branch_kind = BR_NONE;
        imm         = '0;
        case (opcode)
            OPC_OP:
            begin
                reg_we = 1'b1;
                alu_op = (funct3 == 3'b000 && funct7_b5) ? ALU_SUB : arith_op;
            end
            OPC_OP_IMM:
            begin
                reg_we    = 1'b1;
                alu_op    = arith_op;
                b_sel_imm = 1'b1;
                imm       = imm_i;
            end
            OPC_LUI:
            begin
                reg_we    = 1'b1;
                alu_op    = ALU_PASS_B;
                b_sel_imm = 1'b1;
                imm       = imm_u;
            end
            OPC_AUIPC:
            begin
                reg_we    = 1'b1;
                a_sel_pc  = 1'b1;
                b_sel_imm = 1'b1;
                imm       = imm_u;
            end
            OPC_LOAD:
            begin
                reg_we    = (funct3 == 3'b010);     // lw only
                wb_sel    = WB_MEM;
                b_sel_imm = 1'b1;
                imm       = imm_i;
            end
            OPC_STORE:
            begin
                mem_we    = (funct3 == 3'b010);     // sw only
                b_sel_imm = 1'b1;
                imm       = imm_s;
            end
            OPC_BRANCH:
            begin
                imm = imm_b;
                case (funct3[2:1])
                    2'b00:   alu_op = ALU_SUB;
                    2'b10:   alu_op = ALU_SLT;
                    default: alu_op = ALU_SLTU;
                endcase
                case (funct3)
                    3'b000:         branch_kind = BR_EQ;
                    3'b001:         branch_kind = BR_NE;
                    3'b100, 3'b110: branch_kind = BR_LT;
                    3'b101, 3'b111: branch_kind = BR_GE;
                    default:        branch_kind = BR_NONE;
                endcase
            end
            OPC_JAL:
            begin
                reg_we      = 1'b1;
                wb_sel      = WB_LINK;
                branch_kind = BR_JAL;
                imm         = imm_j;
            end
            OPC_JALR:
            begin
                reg_we      = 1'b1;
                wb_sel      = WB_LINK;
                branch_kind = BR_JALR;
                imm         = imm_i;
            end
            default:
            begin
                reg_we = 1'b0;
            end
        endcase
    end

    // Store and register write are exclusive for any instruction word
    always_comb
    begin
        assert (!(mem_we && reg_we))
            else $error("decoder asserts both mem_we and reg_we");
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    input  rv_pkg::alu_op_e         op,
    output logic [rv_pkg::XLEN-1:0] result
);
    import rv_pkg::*;

    logic [XLEN-1:0] b_inv;
    logic [XLEN-1:0] diff;
    logic            carry;
    logic            overflow;
    logic            less_signed;
    logic            less_unsigned;
    logic [4:0]      shamt;

    // a - b as a + ~b + 1, carry out kept for unsigned compare
    assign b_inv         = ~b;
    assign {carry, diff} = {1'b0, a} + {1'b0, b_inv} + 1'b1;

    assign overflow      = (a[XLEN-1] == b_inv[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);
    assign less_signed   = diff[XLEN-1] ^ overflow;
    assign less_unsigned = ~carry;      // Borrow out

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = diff;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, less_signed};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, less_unsigned};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                      rdclk,
    input  logic                      rst,
    input  logic [rv_pkg::REG_AW-1:0] rs1,
    input  logic [rv_pkg::REG_AW-1:0] rs2,
    input  logic [rv_pkg::REG_AW-1:0] rd,
    input  logic                      we,
    input  logic [rv_pkg::XLEN-1:0]   wdata,
    output logic [rv_pkg::XLEN-1:0]   rs1_data,
    output logic [rv_pkg::XLEN-1:0]   rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [0:31];     // x0 cleared on reset, never written

    always_ff @(posedge rdclk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && rd != '0)
        begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    a_x0_zero_rs1: assert property (@(posedge rdclk) disable iff (rst)
        (rs1 == '0) |-> (rs1_data == '0));

    a_x0_zero_rs2: assert property (@(posedge rdclk) disable iff (rst)
        (rs2 == '0) |-> (rs2_data == '0));

endmodule

// ==== hw/next_pc_unit.sv ====
`timescale 1ns/100ps

module next_pc_unit (
    input  logic                    rdclk,
    input  logic                    rst,
    input  rv_pkg::branch_e         branch_kind,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic [rv_pkg::XLEN-1:0] pc_plus4
);
    import rv_pkg::*;

    logic            taken;
    logic [XLEN-1:0] jalr_target;
    logic [XLEN-1:0] next_pc;

    // ALU result carries the comparison for branches
    always_comb
    begin
        case (branch_kind)
            BR_EQ:   taken = (alu_result == '0);
            BR_NE:   taken = (alu_result != '0);
            BR_LT:   taken = alu_result[0];
            BR_GE:   taken = ~alu_result[0];
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4    = pc + XLEN'(4);
    assign jalr_target = (rs1_data + imm) & ~XLEN'(1);
    assign next_pc     = (branch_kind == BR_JALR) ? jalr_target :
                         taken ? (pc + imm) : pc_plus4;

    always_ff @(posedge rdclk)
    begin
        if (rst)
            pc <= RESET_PC;
        else
            pc <= next_pc;
    end

    // Catches misaligned jalr targets coming from register data
    a_pc_aligned: assert property (@(posedge rdclk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// ==== hw/rv32_core.sv ====
`timescale 1ns/100ps

module rv32_core (
    input  logic                    rdclk,
    input  logic                    rst,
    output logic [rv_pkg::XLEN-1:0] imem_addr,
    input  logic [rv_pkg::XLEN-1:0] imem_data,
    output logic [rv_pkg::XLEN-1:0] dmem_addr,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata,
    output logic                    dmem_we,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata,
    output logic [rv_pkg::XLEN-1:0] dbg_pc
);
    import rv_pkg::*;

    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic              dec_reg_we;
    logic              dec_mem_we;
    logic              reg_we;
    alu_op_e           alu_op;
    logic              a_sel_pc;
    logic              b_sel_imm;
    wb_e               wb_sel;
    branch_e           branch_kind;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   alu_a;
    logic [XLEN-1:0]   alu_b;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   pc_plus4;
    logic [XLEN-1:0]   wb_data;

    instr_decoder decoder_i (
        .instr       (imem_data),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .reg_we      (dec_reg_we),
        .mem_we      (dec_mem_we),
        .alu_op      (alu_op),
        .a_sel_pc    (a_sel_pc),
        .b_sel_imm   (b_sel_imm),
        .wb_sel      (wb_sel),
        .branch_kind (branch_kind),
        .imm         (imm)
    );

    assign alu_a = a_sel_pc ? pc : rs1_data;
    assign alu_b = b_sel_imm ? imm : rs2_data;

    alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    always_comb
    begin
        case (wb_sel)
            WB_MEM:  wb_data = dmem_rdata;
            WB_LINK: wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    // No writes of either kind while in reset
    assign reg_we  = dec_reg_we & ~rst;
    assign dmem_we = dec_mem_we & ~rst;

    reg_file reg_file_i (
        .rdclk    (rdclk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (reg_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    next_pc_unit next_pc_i (
        .rdclk       (rdclk),
        .rst         (rst),
        .branch_kind (branch_kind),
        .alu_result  (alu_result),
        .imm         (imm),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    assign imem_addr  = pc;
    assign dbg_pc     = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;

endmodule

// ==== sim/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic rdclk,
    output logic rst
);

    initial
    begin
        rdclk = 1'b0;
        forever #10 rdclk = ~rdclk;     // 20 ns period
    end

    // Reset spans three rising edges, released just after the third
    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge rdclk);
        #2;
        rst = 1'b0;
    end

endmodule

// ==== sim/core_tb.sv ====
`timescale 1ns/100ps

module core_tb;
    import rv_pkg::*;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rdata;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } row_t;

    logic            rdclk;
    logic            rst;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_data;
    logic [XLEN-1:0] dmem_addr;
    logic [XLEN-1:0] dmem_wdata;
    logic            dmem_we;
    logic [XLEN-1:0] dmem_rdata;
    logic [XLEN-1:0] dbg_pc;

    row_t  rows[$];
    string names[$];
    int    cycles = 0;

    clock_gen clock_gen_i (
        .rdclk (rdclk),
        .rst   (rst)
    );

    rv32_core rv32_core_i (
        .rdclk      (rdclk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .dbg_pc     (dbg_pc)
    );

    function automatic logic [XLEN-1:0] r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic logic [XLEN-1:0] i_type(opcode_e opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [XLEN-1:0] s_type(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [XLEN-1:0] b_type(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [XLEN-1:0] u_type(opcode_e opc, int rd, int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [XLEN-1:0] j_type(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic plain_row(string name, logic [XLEN-1:0] pc, logic [XLEN-1:0] instr);
        rows.push_back('{instr, pc, '0, 1'b0, '0, '0});
        names.push_back(name);
    endtask

    task automatic load_row(string name, logic [XLEN-1:0] pc, logic [XLEN-1:0] instr,
                            logic [XLEN-1:0] rdata);
        rows.push_back('{instr, pc, rdata, 1'b0, '0, '0});
        names.push_back(name);
    endtask

    task automatic store_row(string name, logic [XLEN-1:0] pc, logic [XLEN-1:0] instr,
                             logic [XLEN-1:0] addr, logic [XLEN-1:0] wdata);
        rows.push_back('{instr, pc, '0, 1'b1, addr, wdata});
        names.push_back(name);
    endtask

    // x1 = 0x100 base, x2 = 25, x3 = -7
    task automatic build_program();
        plain_row("addi_base", 'h00, i_type(OPC_OP_IMM, 0, 1, 0, 'h100));
        plain_row("addi_pos",  'h04, i_type(OPC_OP_IMM, 0, 2, 0, 25));
        plain_row("addi_neg",  'h08, i_type(OPC_OP_IMM, 0, 3, 0, -7));
        plain_row("add",       'h0C, r_type(0, 0, 4, 2, 3));
        store_row("sw_add",    'h10, s_type(4, 1, 0), 'h100, 'h12);
        plain_row("sub",       'h14, r_type('h20, 0, 5, 2, 3));
        store_row("sw_sub",    'h18, s_type(5, 1, 4), 'h104, 'h20);
        plain_row("xor",       'h1C, r_type(0, 4, 6, 2, 3));
        store_row("sw_xor",    'h20, s_type(6, 1, 8), 'h108, 'hFFFF_FFE0);
        plain_row("or",        'h24, r_type(0, 6, 7, 2, 3));
        plain_row("and",       'h28, r_type(0, 7, 8, 2, 3));
        store_row("sw_or",     'h2C, s_type(7, 1, 12), 'h10C, 'hFFFF_FFF9);
        store_row("sw_and",    'h30, s_type(8, 1, -4), 'h0FC, 'h19);     // Negative offset
        plain_row("addi_shamt", 'h34, i_type(OPC_OP_IMM, 0, 9, 0, 4));
        plain_row("sll",       'h38, r_type(0, 1, 10, 3, 9));
        plain_row("srl",       'h3C, r_type(0, 5, 11, 3, 9));
        plain_row("sra",       'h40, r_type('h20, 5, 12, 3, 9));
        store_row("sw_sll",    'h44, s_type(10, 1, 16), 'h110, 'hFFFF_FF90);
        store_row("sw_srl",    'h48, s_type(11, 1, 20), 'h114, 'h0FFF_FFFF);
        store_row("sw_sra",    'h4C, s_type(12, 1, 24), 'h118, 'hFFFF_FFFF);

        // Signed and unsigned orderings disagree for -7 vs 25
        plain_row("slt",       'h50, r_type(0, 2, 13, 3, 2));
        plain_row("sltu",      'h54, r_type(0, 3, 14, 3, 2));
        store_row("sw_slt",    'h58, s_type(13, 1, 28), 'h11C, 1);
        store_row("sw_sltu",   'h5C, s_type(14, 1, 32), 'h120, 0);
        plain_row("sltiu",     'h60, i_type(OPC_OP_IMM, 3, 15, 2, -1));
        store_row("sw_sltiu",  'h64, s_type(15, 1, 36), 'h124, 1);

        load_row("lw",         'h68, i_type(OPC_LOAD, 2, 16, 1, 40), 'hCAFE_F00D);
        store_row("sw_lw",     'h6C, s_type(16, 1, 44), 'h12C, 'hCAFE_F00D);

        plain_row("beq_t",     'h70, b_type(0, 2, 2, 8));
        plain_row("beq_n",     'h78, b_type(0, 2, 3, 8));
        plain_row("bne_t",     'h7C, b_type(1, 2, 3, 8));
        plain_row("bne_n",     'h84, b_type(1, 2, 2, 8));
        plain_row("blt_t",     'h88, b_type(4, 3, 2, 8));
        plain_row("blt_n",     'h90, b_type(4, 2, 3, 8));
        plain_row("bge_t",     'h94, b_type(5, 2, 3, 8));
        plain_row("bge_n",     'h9C, b_type(5, 3, 2, 8));
        plain_row("bltu_t",    'hA0, b_type(6, 2, 3, 8));
        plain_row("bltu_n",    'hA8, b_type(6, 3, 2, 8));
        plain_row("bgeu_t",    'hAC, b_type(7, 3, 2, 8));
        plain_row("bgeu_n",    'hB4, b_type(7, 2, 3, 8));

        plain_row("jal",       'hB8, j_type(17, 16));
        store_row("sw_jal",    'hC8, s_type(17, 1, 48), 'h130, 'hBC);
        plain_row("addi_odd",  'hCC, i_type(OPC_OP_IMM, 0, 18, 0, 'hE5));
        plain_row("jalr",      'hD0, i_type(OPC_JALR, 0, 19, 18, 'h14));  // 0xF9 -> 0xF8
        store_row("sw_jalr",   'hF8, s_type(19, 1, 52), 'h134, 'hD4);
        plain_row("lui",       'hFC, u_type(OPC_LUI, 20, 'h12345));
        store_row("sw_lui",    'h100, s_type(20, 1, 56), 'h138, 'h1234_5000);
        plain_row("auipc",     'h104, u_type(OPC_AUIPC, 21, 'hABCDE));
        store_row("sw_auipc",  'h108, s_type(21, 1, 60), 'h13C, 'hABCD_E104);
        plain_row("addi_x0",   'h10C, i_type(OPC_OP_IMM, 0, 0, 0, 5));
        plain_row("add_x0",    'h110, r_type(0, 0, 0, 2, 3));
        store_row("sw_x0",     'h114, s_type(0, 1, 64), 'h140, 0);
        plain_row("jal_back",  'h118, j_type(0, -'h118));
        plain_row("unknown",   'h00, 'h0000_017F);          // Acts as nop, rd field is x2
        store_row("sw_after",  'h04, s_type(2, 1, 68), 'h144, 'h19);
    endtask

    task automatic compare_values(string name, logic [XLEN-1:0] expected,
                                  logic [XLEN-1:0] actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected 0x%h, actual 0x%h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic verify_outputs(int i);
        row_t r;
        r = rows[i];
        compare_values({names[i], " imem_addr"}, r.pc, imem_addr);
        compare_values({names[i], " dbg_pc"}, r.pc, dbg_pc);
        compare_values({names[i], " dmem_we"}, 32'(r.we), 32'(dmem_we));
        if (r.we)
        begin
            compare_values({names[i], " dmem_addr"}, r.addr, dmem_addr);
            compare_values({names[i], " dmem_wdata"}, r.wdata, dmem_wdata);
        end
    endtask

    // Rows plus reset plus some slack
    always @(posedge rdclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= rows.size() + 3 + 20)
        begin
            $display("Checks failed");
            $fatal(1, "Timeout: program did not finish after %0d cycles", cycles);
        end
    end

    initial
    begin
        imem_data  = 'h0000_0013;   // nop
        dmem_rdata = '0;
        build_program();
        @(negedge rst);             // 2 ns after the last reset edge
        for (int i = 0; i < rows.size(); i++)
        begin
            imem_data  = rows[i].instr;
            dmem_rdata = rows[i].rdata;
            #16;
            verify_outputs(i);
            @(posedge rdclk);
            #2;
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/rv_pkg.sv
hw/instr_decoder.sv
hw/alu.sv
hw/reg_file.sv
hw/next_pc_unit.sv
hw/rv32_core.sv
sim/clock_gen.sv
sim/core_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module core_tb \
		-f tb.f -Mdir obj_dir -o core_tb

run: compile
	@out="$$(./obj_dir/core_tb 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
